/* all.f */
+incdir+design
design/n64_loader_pkg.sv
design/download_decode.sv
design/halfword_packer.sv
design/ram_write_port.sv
design/backup_control.sv
design/n64_loader_top.sv
tb/tb_clock.sv
tb/tb_top.sv

/* design/backup_control.sv */
//==========================================================================
// Mount is taken on any non-empty writable image, even mid-download
// Requests are combinational, the core samples them itself
//==========================================================================
`include "n64_loader_macros.svh"

module backup_control (
	input  logic                          clk_1x,
	input  logic                          rst_n,
	input  n64_loader_pkg::dl_target_t    target,
	input  n64_loader_pkg::img_info_t     img,
	input  n64_loader_pkg::menu_opts_t    opts,
	input  logic                          osd_status,
	output logic                          use_img,
	output logic                          cart_loaded,
	output logic                          bk_load,
	output logic                          bk_save,
	output logic                          led_user,
	output n64_loader_pkg::eeprom_type_t  eeprom_type
);

	logic img_usable;

	assign img_usable = img.mounted && img.size_nonzero && !img.readonly;

	//======================================================================
	// Image and cartridge state
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			use_img     <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			// New mount beats the clear from a new cartridge
			if (img_usable) begin
				use_img <= 1'b1;
			end else if (target.cart_start) begin
				use_img <= 1'b0;
			end
			// Sticky
			if (target.cart_active) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	//======================================================================
	// Requests
	//======================================================================

	// Load also on a fresh cartridge with an image present
	assign bk_load = opts.menu_load || (target.cart_active && img.mounted);

	// OSD open triggers autosave
	assign bk_save = opts.menu_save || (osd_status && !opts.autosave_off);

	assign led_user = target.cart_active;

	// EEPROM type from the save type, others have no EEPROM
	always_comb begin
		case (opts.save_type)
			3'(`N64_SAVE_EEPROM4):  eeprom_type = 2'd1;
			3'(`N64_SAVE_EEPROM16): eeprom_type = 2'd2;
			default:                eeprom_type = 2'd0;
		endcase
	end

endmodule

/* design/download_decode.sv */
//==========================================================================
// Active flags lag download/index by one cycle
// cart_start is high in the first cycle of cart_active only
//==========================================================================
`include "n64_loader_macros.svh"

module download_decode (
	input  logic                        clk_1x,
	input  logic                        rst_n,
	input  n64_loader_pkg::ioctl_t      ioctl,
	output n64_loader_pkg::dl_target_t  target
);

	logic [`N64_IDX_BITS-1:0] idx_low;
	logic                     is_pif;
	logic                     is_cart;
	logic                     pif_q;
	logic                     cart_q;
	logic                     cart_prev;

	// Only the low index bits select the target
	assign idx_low = ioctl.index[`N64_IDX_BITS-1:0];
	assign is_pif  = ioctl.download && (idx_low == `N64_IDX_BITS'(`N64_IDX_PIFROM));
	assign is_cart = ioctl.download && (idx_low == `N64_IDX_BITS'(`N64_IDX_CART));

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_q     <= 1'b0;
			cart_q    <= 1'b0;
			cart_prev <= 1'b0;
		end else begin
			pif_q     <= is_pif;
			cart_q    <= is_cart;
			cart_prev <= cart_q;
		end
	end

	// Rising edge of the cartridge flag
	assign target = '{
		pif_active:  pif_q,
		cart_active: cart_q,
		cart_start:  cart_q && !cart_prev
	};

	//======================================================================
	// Checks
	//======================================================================

	// Only one image can be in flight
	a_one_target: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		!(target.pif_active && target.cart_active)
	);

endmodule

/* design/halfword_packer.sv */
//==========================================================================
// Low half (addr bit 1 clear) must come before its high half
// Host leaves two idle cycles after each high half, data holds until used
//==========================================================================
`include "n64_loader_macros.svh"

module halfword_packer (
	input  logic                          clk_1x,
	input  logic                          rst_n,
	input  n64_loader_pkg::ioctl_t        ioctl,
	input  n64_loader_pkg::dl_target_t    target,
	output n64_loader_pkg::packed_word_t  word
);

	logic                      capture;
	logic                      hi_seen;
	logic                      valid_q;
	logic                      is_cart_q;
	n64_loader_pkg::half_t     swapped;
	n64_loader_pkg::dl_addr_t  cart_base;
	n64_loader_pkg::dl_addr_t  addr_q;
	n64_loader_pkg::word_t     data_q;

	// Strobe only counts while a target is active
	assign capture = ioctl.wr && (target.pif_active || target.cart_active);

	// PIF ROM is stored big endian
	assign swapped = {ioctl.dout[7:0], ioctl.dout[15:8]};

	assign cart_base = n64_loader_pkg::dl_addr_t'(`N64_CART_BASE);

	//======================================================================
	// Control
	//======================================================================

	// High half at edge N, valid after edge N+1
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			hi_seen <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			hi_seen <= capture && ioctl.addr[1];
			valid_q <= hi_seen;
		end
	end

	//======================================================================
	// Word assembly
	//======================================================================

	always_ff @(posedge clk_1x) begin
		if (capture) begin
			if (!ioctl.addr[1]) begin
				// Low half fixes the address
				if (target.cart_active) begin
					data_q[15:0] <= ioctl.dout;
					addr_q       <= ioctl.addr + cart_base;
				end else begin
					data_q[31:16] <= swapped;
					addr_q        <= ioctl.addr;
				end
			end else begin
				if (target.cart_active) begin
					data_q[31:16] <= ioctl.dout;
				end else begin
					data_q[15:0] <= swapped;
				end
				is_cart_q <= target.cart_active;
			end
		end
	end

	assign word = '{
		valid:   valid_q,
		is_cart: is_cart_q,
		addr:    addr_q,
		data:    data_q
	};

	// One pulse per word
	a_valid_single: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		word.valid |=> !word.valid
	);

endmodule

/* design/n64_loader_macros.svh */
//==========================================================================
// Download indices match the host menu order, PIF ROM first
// Only the low N64_IDX_BITS of the host index are compared
//==========================================================================
`ifndef N64_LOADER_MACROS_SVH
`define N64_LOADER_MACROS_SVH

//==========================================================================
// Download targets
//==========================================================================

// Host index of the PIF ROM image
`define N64_IDX_PIFROM 0
// Host index of the cartridge image
`define N64_IDX_CART 1
// Index bits taken into the compare
`define N64_IDX_BITS 6

// Byte offset of the cartridge in RAM (8 MB)
`define N64_CART_BASE 8388608

//==========================================================================
// Menu save-type codes
//==========================================================================

// 4 kbit EEPROM
`define N64_SAVE_EEPROM4 1
// 16 kbit EEPROM
`define N64_SAVE_EEPROM16 2

`endif

/* design/n64_loader_pkg.sv */
//==========================================================================
// Types shared by the loader front end; struct field order is fixed
//==========================================================================
package n64_loader_pkg;

	//======================================================================
	// Widths with a meaning
	//======================================================================

	// Host halfword and packed RAM word
	typedef logic [15:0] half_t;
	typedef logic [31:0] word_t;

	// Host byte address, PIF ROM word address
	typedef logic [26:0] dl_addr_t;
	typedef logic [8:0] pif_addr_t;

	// Download index from the host
	typedef logic [7:0] dl_index_t;

	// Save type from the menu, EEPROM type to the core
	typedef logic [2:0] save_type_t;
	typedef logic [1:0] eeprom_type_t;

	//======================================================================
	// Bundles
	//======================================================================

	// Host download port
	typedef struct packed {
		logic      download;
		dl_index_t index;
		dl_addr_t  addr;
		logic      wr;
		half_t     dout;
	} ioctl_t;

	// Active download target
	typedef struct packed {
		logic pif_active;
		logic cart_active;
		logic cart_start;
	} dl_target_t;

	// Complete word on its way to a write port
	typedef struct packed {
		logic     valid;
		logic     is_cart;
		dl_addr_t addr;
		word_t    data;
	} packed_word_t;

	// Menu options for the backup RAM
	typedef struct packed {
		save_type_t save_type;
		logic       menu_load;
		logic       menu_save;
		logic       autosave_off;
	} menu_opts_t;

	// Mounted image state
	typedef struct packed {
		logic mounted;
		logic readonly;
		logic size_nonzero;
	} img_info_t;

endpackage

/* design/n64_loader_top.sv */
//==========================================================================
// Download and backup-control front end, single clock domain
// Host must honour ioctl_wait and pair halfwords low then high
//==========================================================================
module n64_loader_top (
	input  logic                          clk_1x,
	input  logic                          rst_n,
	// Host download port
	input  n64_loader_pkg::ioctl_t        ioctl,
	output logic                          ioctl_wait,
	// PIF ROM write port
	output logic                          pif_wren,
	output n64_loader_pkg::pif_addr_t     pif_addr,
	output n64_loader_pkg::word_t         pif_data,
	// Cartridge RAM write port
	output logic                          cart_wr,
	output n64_loader_pkg::dl_addr_t      cart_addr,
	output n64_loader_pkg::word_t         cart_data,
	input  logic                          ram_ready,
	// Backup RAM side
	input  n64_loader_pkg::img_info_t     img,
	input  n64_loader_pkg::menu_opts_t    opts,
	input  logic                          osd_status,
	output logic                          use_img,
	output logic                          bk_load,
	output logic                          bk_save,
	output logic                          cart_loaded,
	output logic                          led_user,
	output n64_loader_pkg::eeprom_type_t  eeprom_type
);

	n64_loader_pkg::dl_target_t    target;
	n64_loader_pkg::packed_word_t  word;

	download_decode u_decode (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.ioctl  (ioctl),
		.target (target)
	);

	halfword_packer u_packer (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.ioctl  (ioctl),
		.target (target),
		.word   (word)
	);

	ram_write_port u_write (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.word        (word),
		.cart_active (target.cart_active),
		.ram_ready   (ram_ready),
		.pif_wren    (pif_wren),
		.pif_addr    (pif_addr),
		.pif_data    (pif_data),
		.cart_wr     (cart_wr),
		.cart_addr   (cart_addr),
		.cart_data   (cart_data),
		.ioctl_wait  (ioctl_wait)
	);

	backup_control u_backup (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.target      (target),
		.img         (img),
		.opts        (opts),
		.osd_status  (osd_status),
		.use_img     (use_img),
		.cart_loaded (cart_loaded),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.led_user    (led_user),
		.eeprom_type (eeprom_type)
	);

endmodule

/* design/ram_write_port.sv */
//==========================================================================
// Write strobes are one-cycle pulses, address and data hold afterwards
// ioctl_wait covers cartridge writes only, PIF ROM writes never stall
//==========================================================================
module ram_write_port (
	input  logic                          clk_1x,
	input  logic                          rst_n,
	input  n64_loader_pkg::packed_word_t  word,
	input  logic                          cart_active,
	input  logic                          ram_ready,
	output logic                          pif_wren,
	output n64_loader_pkg::pif_addr_t     pif_addr,
	output n64_loader_pkg::word_t         pif_data,
	output logic                          cart_wr,
	output n64_loader_pkg::dl_addr_t      cart_addr,
	output n64_loader_pkg::word_t         cart_data,
	output logic                          ioctl_wait
);

	logic pif_hit;
	logic cart_hit;

	assign pif_hit  = word.valid && !word.is_cart;
	assign cart_hit = word.valid && word.is_cart;

	//======================================================================
	// Strobes and wait level
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_wren   <= 1'b0;
			cart_wr    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			pif_wren <= pif_hit;
			cart_wr  <= cart_hit;
			// End of download releases the host regardless of RAM
			if (!cart_active) begin
				ioctl_wait <= 1'b0;
			end else if (cart_hit) begin
				ioctl_wait <= 1'b1;
			end else if (ram_ready) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	//======================================================================
	// Address and data
	//======================================================================

	always_ff @(posedge clk_1x) begin
		if (pif_hit) begin
			// PIF ROM port is word addressed
			pif_addr <= word.addr[10:2];
			pif_data <= word.data;
		end
		if (cart_hit) begin
			cart_addr <= word.addr;
			cart_data <= word.data;
		end
	end

	// Wait never outlives the cartridge download
	a_wait_ends: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		!cart_active |=> !ioctl_wait
	);

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator and run, status follows the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_top -f all.f -Mdir obj_dir &&
./obj_dir/Vtb_top | tee /dev/stderr | grep "Simulation passed" > /dev/null ||
exit 1

/* tb/tb_clock.sv */
//==========================================================================
// Free-running 10-unit clock, reset held low for the first 16 edges
//==========================================================================
module tb_clock (
	output logic clk_1x,
	output logic rst_n
);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	// Release lands on a rising edge
	initial begin
		rst_n <= 1'b0;
		repeat (16) @(posedge clk_1x);
		rst_n <= 1'b1;
	end

endmodule

/* tb/tb_top.sv */
//==========================================================================
// Host side never sends wr while ioctl_wait is high
// Concurrent assertions below do all of the checking
//==========================================================================
`include "n64_loader_macros.svh"

module tb_top;

	logic                          clk_1x;
	logic                          rst_n;
	n64_loader_pkg::ioctl_t        ioctl;
	logic                          ioctl_wait;
	logic                          pif_wren;
	n64_loader_pkg::pif_addr_t     pif_addr;
	n64_loader_pkg::word_t         pif_data;
	logic                          cart_wr;
	n64_loader_pkg::dl_addr_t      cart_addr;
	n64_loader_pkg::word_t         cart_data;
	logic                          ram_ready;
	n64_loader_pkg::img_info_t     img;
	n64_loader_pkg::menu_opts_t    opts;
	logic                          osd_status;
	logic                          use_img;
	logic                          bk_load;
	logic                          bk_save;
	logic                          cart_loaded;
	logic                          led_user;
	n64_loader_pkg::eeprom_type_t  eeprom_type;

	integer seed;
	int     errors;
	int     tests;

	// Expected word of the pair in flight
	n64_loader_pkg::word_t     exp_data;
	n64_loader_pkg::dl_addr_t  exp_addr;

	// Reference timing
	logic pif_dl_d1;
	logic cart_dl_d1;
	logic cart_dl_d2;
	logic pif_hi_d1;
	logic pif_hi_d2;
	logic pif_due;
	logic cart_hi_d1;
	logic cart_hi_d2;
	logic cart_due;
	logic exp_use_img;
	logic exp_cart_loaded;

	tb_clock u_clock (
		.clk_1x (clk_1x),
		.rst_n  (rst_n)
	);

	n64_loader_top DUT (.*);

	//======================================================================
	// Reference model
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_dl_d1       <= 1'b0;
			cart_dl_d1      <= 1'b0;
			cart_dl_d2      <= 1'b0;
			pif_hi_d1       <= 1'b0;
			pif_hi_d2       <= 1'b0;
			pif_due         <= 1'b0;
			cart_hi_d1      <= 1'b0;
			cart_hi_d2      <= 1'b0;
			cart_due        <= 1'b0;
			exp_use_img     <= 1'b0;
			exp_cart_loaded <= 1'b0;
		end else begin
			pif_dl_d1  <= ioctl.download &&
				(ioctl.index == n64_loader_pkg::dl_index_t'(`N64_IDX_PIFROM));
			cart_dl_d1 <= ioctl.download &&
				(ioctl.index == n64_loader_pkg::dl_index_t'(`N64_IDX_CART));
			cart_dl_d2 <= cart_dl_d1;
			// High half to write strobe takes two edges
			pif_hi_d1  <= ioctl.wr && ioctl.addr[1] && pif_dl_d1;
			pif_hi_d2  <= pif_hi_d1;
			pif_due    <= pif_hi_d2;
			cart_hi_d1 <= ioctl.wr && ioctl.addr[1] && cart_dl_d1;
			cart_hi_d2 <= cart_hi_d1;
			cart_due   <= cart_hi_d2;
			if (img.mounted && img.size_nonzero && !img.readonly) begin
				exp_use_img <= 1'b1;
			end else if (cart_dl_d1 && !cart_dl_d2) begin
				exp_use_img <= 1'b0;
			end
			if (cart_dl_d1) begin
				exp_cart_loaded <= 1'b1;
			end
		end
	end

	function automatic n64_loader_pkg::eeprom_type_t eeprom_rule(
			input n64_loader_pkg::save_type_t st);
		if (st == 3'(`N64_SAVE_EEPROM4))
			return 2'd1;
		if (st == 3'(`N64_SAVE_EEPROM16))
			return 2'd2;
		return 2'd0;
	endfunction

	function automatic void report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("mismatch at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
	endfunction

	function automatic void report_timeout(input string what);
		errors++;
		$display("timeout at time %0t: %s", $time, what);
	endfunction

	function automatic void finish_test(input string name);
		tests++;
		$display("test %0d (%s) finished, %0d failed checks so far", tests, name, errors);
	endfunction

	//======================================================================
	// Checks
	//======================================================================

	a_pif_strobe: assert property (@(posedge clk_1x) disable iff (!rst_n) pif_wren == pif_due)
		else report_mismatch("pif_wren", 32'($sampled(pif_wren)), 32'($sampled(pif_due)));
	a_pif_data: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif_due |-> pif_data == exp_data)
		else report_mismatch("pif_data", $sampled(pif_data), $sampled(exp_data));
	a_pif_addr: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif_due |-> pif_addr == exp_addr[10:2])
		else report_mismatch("pif_addr", 32'($sampled(pif_addr)),
			32'($sampled(exp_addr[10:2])));

	a_cart_strobe: assert property (@(posedge clk_1x) disable iff (!rst_n) cart_wr == cart_due)
		else report_mismatch("cart_wr", 32'($sampled(cart_wr)), 32'($sampled(cart_due)));
	a_cart_data: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_due |-> cart_data == exp_data)
		else report_mismatch("cart_data", $sampled(cart_data), $sampled(exp_data));
	a_cart_addr: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_due |-> cart_addr == exp_addr)
		else report_mismatch("cart_addr", 32'($sampled(cart_addr)), 32'($sampled(exp_addr)));

	// Wait level around each cartridge write
	a_wait_rise: assert property (@(posedge clk_1x) disable iff (!rst_n) cart_due |-> ioctl_wait)
		else report_mismatch("ioctl_wait", 32'($sampled(ioctl_wait)), 32'd1);
	a_wait_release: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_ready |=> !ioctl_wait)
		else report_mismatch("ioctl_wait", 32'($sampled(ioctl_wait)), 32'd0);
	a_wait_hold: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait && !ram_ready && cart_dl_d1 |=> ioctl_wait)
		else report_mismatch("ioctl_wait", 32'($sampled(ioctl_wait)), 32'd1);
	a_wait_end: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!cart_dl_d2 |-> !ioctl_wait)
		else report_mismatch("ioctl_wait", 32'($sampled(ioctl_wait)), 32'd0);

	a_use_img: assert property (@(posedge clk_1x) disable iff (!rst_n) use_img == exp_use_img)
		else report_mismatch("use_img", 32'($sampled(use_img)), 32'($sampled(exp_use_img)));
	a_cart_loaded: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_loaded == exp_cart_loaded)
		else report_mismatch("cart_loaded", 32'($sampled(cart_loaded)),
			32'($sampled(exp_cart_loaded)));
	a_bk_load: assert property (@(posedge clk_1x) disable iff (!rst_n)
		bk_load == (opts.menu_load || (cart_dl_d1 && img.mounted)))
		else report_mismatch("bk_load", 32'($sampled(bk_load)),
			32'($sampled(opts.menu_load || (cart_dl_d1 && img.mounted))));
	a_bk_save: assert property (@(posedge clk_1x) disable iff (!rst_n)
		bk_save == (opts.menu_save || (osd_status && !opts.autosave_off)))
		else report_mismatch("bk_save", 32'($sampled(bk_save)),
			32'($sampled(opts.menu_save || (osd_status && !opts.autosave_off))));
	a_led_user: assert property (@(posedge clk_1x) disable iff (!rst_n) led_user == cart_dl_d1)
		else report_mismatch("led_user", 32'($sampled(led_user)), 32'($sampled(cart_dl_d1)));
	a_eeprom: assert property (@(posedge clk_1x) disable iff (!rst_n)
		eeprom_type == eeprom_rule(opts.save_type))
		else report_mismatch("eeprom_type", 32'($sampled(eeprom_type)),
			32'(eeprom_rule($sampled(opts.save_type))));

	//======================================================================
	// Host and RAM side
	//======================================================================

	task automatic step(input int n);
		repeat (n) @(posedge clk_1x);
	endtask

	task automatic send_half(input n64_loader_pkg::dl_addr_t addr,
			input n64_loader_pkg::half_t data);
		ioctl.addr <= addr;
		ioctl.dout <= data;
		ioctl.wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl.wr <= 1'b0;
	endtask

	// Low half then high half on back-to-back cycles
	task automatic send_pair(input n64_loader_pkg::dl_addr_t addr,
			input n64_loader_pkg::half_t lo, input n64_loader_pkg::half_t hi);
		send_half(addr, lo);
		send_half({addr[26:2], 2'b10}, hi);
	endtask

	task automatic pulse_ready();
		ram_ready <= 1'b1;
		@(posedge clk_1x);
		ram_ready <= 1'b0;
	endtask

	task automatic await_wait(input logic level, input string what);
		int n;
		n = 0;
		while (ioctl_wait !== level && n < 20) begin
			@(posedge clk_1x);
			n++;
		end
		if (ioctl_wait !== level)
			report_timeout(what);
	endtask

	task automatic await_pif_write();
		int n;
		n = 0;
		while (!pif_wren && n < 10) begin
			@(posedge clk_1x);
			n++;
		end
		if (!pif_wren)
			report_timeout("no PIF ROM write after the high half");
	endtask

	//======================================================================
	// Tests
	//======================================================================

	task automatic test_pif_load();
		n64_loader_pkg::dl_addr_t addr;
		logic [31:0] rnd;
		logic [31:0] rnd_hi;
		ioctl.download <= 1'b1;
		ioctl.index    <= n64_loader_pkg::dl_index_t'(`N64_IDX_PIFROM);
		step(3);
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			rnd_hi = $random(seed);
			addr = {16'd0, rnd[8:0], 2'b00};
			// Both halves land byte swapped, low half on top
			exp_data <= {rnd[23:16], rnd[31:24], rnd_hi[7:0], rnd_hi[15:8]};
			exp_addr <= addr;
			send_pair(addr, rnd[31:16], rnd_hi[15:0]);
			await_pif_write();
			step(2);
		end
		ioctl.download <= 1'b0;
		step(3);
		finish_test("PIF ROM load");
	endtask

	task automatic send_cart_pair();
		n64_loader_pkg::dl_addr_t addr;
		logic [31:0] rnd;
		logic [31:0] rnd_hi;
		rnd = $random(seed);
		rnd_hi = $random(seed);
		addr = {4'd0, rnd[20:0], 2'b00};
		exp_data <= {rnd_hi[15:0], rnd[31:16]};
		exp_addr <= addr + n64_loader_pkg::dl_addr_t'(`N64_CART_BASE);
		send_pair(addr, rnd[31:16], rnd_hi[15:0]);
		await_wait(1'b1, "ioctl_wait did not rise after a cartridge write");
	endtask

	task automatic test_cart_load();
		logic [31:0] rnd;
		ioctl.download <= 1'b1;
		ioctl.index    <= n64_loader_pkg::dl_index_t'(`N64_IDX_CART);
		step(3);
		for (int i = 0; i < 6; i++) begin
			await_wait(1'b0, "ioctl_wait stayed high before a new pair");
			send_cart_pair();
			// RAM answers after a random delay
			rnd = $random(seed);
			step(int'(rnd[2:0]));
			pulse_ready();
			await_wait(1'b0, "ioctl_wait did not fall after ram_ready");
		end
		finish_test("cartridge load");
	endtask

	task automatic test_wait_drop();
		send_cart_pair();
		step(3);
		ioctl.download <= 1'b0;
		step(1);
		await_wait(1'b0, "ioctl_wait did not fall after the download ended");
		step(4);
		finish_test("download ends under wait");
	endtask

	task automatic test_image();
		// Read-only and empty images are ignored while use_img is low
		img <= '{mounted: 1'b1, readonly: 1'b1, size_nonzero: 1'b1};
		step(1);
		img <= '{mounted: 1'b1, readonly: 1'b0, size_nonzero: 1'b0};
		step(1);
		img <= '0;
		step(2);
		img <= '{mounted: 1'b1, readonly: 1'b0, size_nonzero: 1'b1};
		step(1);
		img <= '0;
		step(2);
		// New cartridge drops the image
		ioctl.download <= 1'b1;
		ioctl.index    <= n64_loader_pkg::dl_index_t'(`N64_IDX_CART);
		step(4);
		ioctl.download <= 1'b0;
		step(3);
		finish_test("image tracking");
	endtask

	task automatic test_requests();
		logic [31:0] rnd;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			opts <= '{save_type: 3'(i), menu_load: rnd[0], menu_save: rnd[1],
				autosave_off: rnd[2]};
			osd_status <= rnd[3];
			img <= '{mounted: rnd[4], readonly: 1'b0, size_nonzero: 1'b0};
			if (i == 4) begin
				ioctl.download <= 1'b1;
				ioctl.index    <= n64_loader_pkg::dl_index_t'(`N64_IDX_CART);
			end
			if (i == 12)
				ioctl.download <= 1'b0;
			step(1);
		end
		opts       <= '0;
		osd_status <= 1'b0;
		img        <= '0;
		step(3);
		finish_test("requests and decode");
	endtask

	initial begin
		int n;
		seed       = 7786;
		errors     = 0;
		tests      = 0;
		ioctl      <= '0;
		ram_ready  <= 1'b0;
		img        <= '0;
		opts       <= '0;
		osd_status <= 1'b0;
		exp_data   <= '0;
		exp_addr   <= '0;
		n = 0;
		while (rst_n !== 1'b1 && n < 40) begin
			@(posedge clk_1x);
			n++;
		end
		if (rst_n !== 1'b1)
			report_timeout("reset was never released");
		step(2);
		test_pif_load();
		test_cart_load();
		test_wait_drop();
		test_image();
		test_requests();
		$display("tests run: %0d, failed checks: %0d", tests, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
